//--- filelist.f
verilog/pibus_pkg.sv
verilog/bus_cont.sv
verilog/pibus_mux.sv
verilog/pibus_slave.sv
verilog/pibus_top.sv
dv/pibus_tb.sv

//--- Makefile
TOP := pibus_tb

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -j 0 -f filelist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only -Wall --timing --assert -f filelist.f --top-module $(TOP)

clean:
	rm -rf obj_dir

//--- dv/pibus_tb.sv
`timescale 1ns/1ns

module pibus_tb;
   import pibus_pkg::*;

   localparam int tout_limit  = 20;
   localparam int wait_states = 2;
   localparam int mem_words   = 16;
   localparam int n_transfers = 14;
   localparam opc_t opc_read  = 4'h2;

   logic  clk;
   logic  rst;
   logic  req_0;
   logic  req_1;
   addr_t a_0;
   addr_t a_1;
   opc_t  opc_0;
   opc_t  opc_1;
   logic  lock_0;
   logic  lock_1;
   data_t wdata_0;
   data_t wdata_1;
   logic  gnt_0;
   logic  gnt_1;
   ack_t  ack;
   data_t rdata;
   logic  tout;

   int    seed;
   data_t ref_mem [mem_words];   // expected slave contents
   addr_t wr_addr [4];
   data_t wr_data [4];
   addr_t lock_addr;
   logic  tie_phase;
   int    tie_grants;
   logic  lock_held;             // master 0 owns a locked tenure

   pibus_top #(
      .tout_limit  (tout_limit),
      .wait_states (wait_states),
      .mem_words   (mem_words)
   ) pibus_top_i (
      .clk     (clk),
      .rst     (rst),
      .req_0   (req_0),
      .req_1   (req_1),
      .a_0     (a_0),
      .a_1     (a_1),
      .opc_0   (opc_0),
      .opc_1   (opc_1),
      .lock_0  (lock_0),
      .lock_1  (lock_1),
      .wdata_0 (wdata_0),
      .wdata_1 (wdata_1),
      .gnt_0   (gnt_0),
      .gnt_1   (gnt_1),
      .ack     (ack),
      .rdata   (rdata),
      .tout    (tout)
   );

   always #50 clk = ~clk;

   task automatic fail(input string msg);
      $display("%s", msg);
      $display("Test failed");
      $fatal(1, "run stopped");
   endtask

   function automatic int word_index(input addr_t x);
      return int'(x % addr_t'(mem_words));
   endfunction

   assert property (@(posedge clk) disable iff (rst) !(gnt_0 && gnt_1))
      else fail("both grants high in the same cycle");
   assert property (@(posedge clk) disable iff (rst) tout |=> !tout)
      else fail("tout pulse longer than one cycle");
   assert property (@(posedge clk) disable iff (rst) tout |-> (!gnt_0 && !gnt_1))
      else fail("grant issued together with tout");
   assert property (@(posedge clk) disable iff (rst) lock_held |-> !gnt_1)
      else fail("master 1 granted during the locked tenure of master 0");

   // grant order while both masters compete
   always @(posedge clk)
   begin
      if (tie_phase && (gnt_0 || gnt_1))
      begin
         assert (gnt_1 == tie_grants[0])
            else fail($sformatf("MISMATCH arbitration: expected gnt_1=%0d actual %0d",
                                tie_grants[0], gnt_1));
         tie_grants <= tie_grants + 1;
      end
   end

   task automatic drive(input int m, input logic rq, input addr_t ad, input opc_t op,
                        input logic lk, input data_t wd);
      if (m == 0)
      begin
         req_0   <= rq;
         a_0     <= ad;
         opc_0   <= op;
         lock_0  <= lk;
         wdata_0 <= wd;
      end
      else
      begin
         req_1   <= rq;
         a_1     <= ad;
         opc_1   <= op;
         lock_1  <= lk;
         wdata_1 <= wd;
      end
   endtask

   // called on a rising edge, returns on the edge where the result is seen
   task automatic transfer(input int m, input string name, input bit new_req,
                           input bit keep_req, input bit check_lat, input addr_t ad,
                           input opc_t op, input logic lk, input data_t wd,
                           input ack_t exp_ack);
      int   cycles;
      int   waits;
      logic seen;
      ack_t result;
      cycles = 0;
      waits  = 0;
      seen   = 1'b0;
      result = ACK_NONE;
      drive(m, new_req, ad, op, lk, wd);
      if (new_req)
      begin
         while (!seen)
         begin
            @(posedge clk);
            cycles++;
            seen = (m == 0) ? gnt_0 : gnt_1;
         end
         if (!keep_req)
         begin
            if (m == 0)
               req_0 <= 1'b0;
            else
               req_1 <= 1'b0;
         end
         // registered grant, seen one edge after the request edge plus one
         if (check_lat)
            assert (cycles == 2)
               else fail($sformatf("MISMATCH %s grant latency: expected 2 actual %0d",
                                   name, cycles));
         cycles = 0;
         seen   = 1'b0;
      end
      while (!seen)
      begin
         @(posedge clk);
         cycles++;
         if (ack == ACK_WAT)
            waits++;
         else if ((ack == ACK_RDY) || (ack == ACK_ERR))
         begin
            result = ack;
            seen   = 1'b1;
         end
         else if (tout)
            seen = 1'b1;
      end
      assert (result == exp_ack)
         else fail($sformatf("MISMATCH %s ack: expected %s actual %s",
                             name, exp_ack.name(), result.name()));
      if (result == ACK_RDY)
      begin
         assert (waits == wait_states)
            else fail($sformatf("MISMATCH %s wait cycles: expected %0d actual %0d",
                                name, wait_states, waits));
         if (op == OPC_WRITE)
            ref_mem[word_index(ad)] = wd;
         else
            assert (rdata == ref_mem[word_index(ad)])
               else fail($sformatf("MISMATCH %s rdata: expected %h actual %h",
                                   name, ref_mem[word_index(ad)], rdata));
      end
      else if (result == ACK_ERR)
      begin
         @(posedge clk);
         assert (tout) else fail("no tout pulse after an error acknowledge");
      end
      else
         // addr cycle, then tout_limit data cycles, then the tout register
         assert (cycles == tout_limit + 2)
            else fail($sformatf("MISMATCH %s tout delay: expected %0d actual %0d",
                                name, tout_limit + 2, cycles));
   endtask

   task automatic check_quiet(input string name);
      assert (!gnt_0 && !gnt_1 && !tout && (ack == ACK_NONE))
         else fail($sformatf("MISMATCH %s: expected 0 0 0 ACK_NONE actual %b %b %b %s",
                             name, gnt_0, gnt_1, tout, ack.name()));
   endtask

   initial
   begin
      #((n_transfers * (tout_limit + 10) + 10) * 100);
      fail("watchdog expired before all transfers finished");
   end

   initial
   begin
      clk        = 1'b0;
      rst        = 1'b1;
      req_0      = 1'b0;
      req_1      = 1'b0;
      a_0        = '0;
      a_1        = '0;
      opc_0      = '0;
      opc_1      = '0;
      lock_0     = 1'b0;
      lock_1     = 1'b0;
      wdata_0    = '0;
      wdata_1    = '0;
      tie_phase  = 1'b0;
      tie_grants = 0;
      lock_held  = 1'b0;
      seed       = 11017;
      for (int i = 0; i < 4; i++)
      begin
         wr_addr[i] = {2'b11, 28'($random(seed))};   // decoded range
         wr_data[i] = $random(seed);
      end
      lock_addr = {2'b11, 28'($random(seed))};

      for (int i = 0; i < 10; i++)
      begin
         @(posedge clk);
         if (i > 0)
            check_quiet("reset");
      end
      rst <= 1'b0;
      repeat (2)
      begin
         @(posedge clk);
         check_quiet("after reset");
      end

      // first transfers keep requesting so each release meets a tie
      tie_phase = 1'b1;
      fork
         begin
            transfer(0, "tie write", 1, 1, 0, wr_addr[0], OPC_WRITE, 0, wr_data[0], ACK_RDY);
            transfer(0, "tie write", 1, 0, 0, wr_addr[1], OPC_WRITE, 0, wr_data[1], ACK_RDY);
         end
         begin
            transfer(1, "tie write", 1, 1, 0, wr_addr[2], OPC_WRITE, 0, wr_data[2], ACK_RDY);
            transfer(1, "tie write", 1, 0, 0, wr_addr[3], OPC_WRITE, 0, wr_data[3], ACK_RDY);
         end
      join
      tie_phase = 1'b0;

      for (int i = 0; i < 4; i++)
         transfer(i % 2, "read back", 1, 0, 1, wr_addr[i], opc_read, 0, '0, ACK_RDY);

      lock_held = 1'b1;
      fork
         begin
            transfer(0, "locked write", 1, 0, 1, lock_addr, OPC_WRITE, 1, $random(seed),
                     ACK_RDY);
            transfer(0, "locked read", 0, 0, 0, lock_addr, opc_read, 1, '0, ACK_RDY);
            drive(0, 0, lock_addr, '0, 0, '0);   // NOP with lock low ends the tenure
            lock_held = 1'b0;
         end
         begin
            repeat (4) @(posedge clk);
            transfer(1, "after lock", 1, 0, 0, wr_addr[1], opc_read, 0, '0, ACK_RDY);
         end
      join

      fork
         transfer(0, "error", 1, 0, 1, wr_addr[2], OPC_LIMIT, 0, $random(seed), ACK_ERR);
         begin
            repeat (3) @(posedge clk);   // pending when the error ends the transfer
            transfer(1, "after error", 1, 0, 0, wr_addr[2], opc_read, 0, '0, ACK_RDY);
         end
      join

      transfer(0, "timeout", 1, 0, 1, {2'b01, 28'($random(seed))}, opc_read, 0, '0, ACK_NONE);
      @(posedge clk);
      check_quiet("after timeout");

      $display("Test completed successfully");
      $finish;
   end

endmodule

//--- verilog/pibus_top.sv
`timescale 1ns/1ns

module pibus_top #(
   parameter int tout_limit  = 255,
   parameter int wait_states = 2,
   parameter int mem_words   = 16
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              req_0,
   input  logic              req_1,
   input  pibus_pkg::addr_t  a_0,
   input  pibus_pkg::addr_t  a_1,
   input  pibus_pkg::opc_t   opc_0,
   input  pibus_pkg::opc_t   opc_1,
   input  logic              lock_0,
   input  logic              lock_1,
   input  pibus_pkg::data_t  wdata_0,
   input  pibus_pkg::data_t  wdata_1,
   output logic              gnt_0,
   output logic              gnt_1,
   output pibus_pkg::ack_t   ack,
   output pibus_pkg::data_t  rdata,
   output logic              tout
);
   import pibus_pkg::*;

   addr_t a;       // owner's fields on the shared bus
   opc_t  opc;
   logic  lock;
   data_t wdata;
   logic  sel;

   bus_cont #(
      .tout_limit (tout_limit)
   ) bus_cont_i (
      .clk   (clk),
      .rst   (rst),
      .req_0 (req_0),
      .req_1 (req_1),
      .a     (a),
      .opc   (opc),
      .lock  (lock),
      .ack   (ack),
      .gnt_0 (gnt_0),
      .gnt_1 (gnt_1),
      .sel   (sel),
      .tout  (tout)
   );

   pibus_mux pibus_mux_i (
      .clk     (clk),
      .rst     (rst),
      .gnt_0   (gnt_0),
      .gnt_1   (gnt_1),
      .a_0     (a_0),
      .a_1     (a_1),
      .opc_0   (opc_0),
      .opc_1   (opc_1),
      .lock_0  (lock_0),
      .lock_1  (lock_1),
      .wdata_0 (wdata_0),
      .wdata_1 (wdata_1),
      .a       (a),
      .opc     (opc),
      .lock    (lock),
      .wdata   (wdata)
   );

   pibus_slave #(
      .wait_states (wait_states),
      .mem_words   (mem_words)
   ) pibus_slave_i (
      .clk   (clk),
      .rst   (rst),
      .sel   (sel),
      .a     (a),
      .opc   (opc),
      .wdata (wdata),
      .ack   (ack),
      .rdata (rdata)
   );

endmodule

//--- verilog/pibus_slave.sv
`timescale 1ns/1ns

module pibus_slave #(
   parameter int wait_states = 2,
   parameter int mem_words   = 16
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              sel,
   input  pibus_pkg::addr_t  a,
   input  pibus_pkg::opc_t   opc,
   input  pibus_pkg::data_t  wdata,
   output pibus_pkg::ack_t   ack,
   output pibus_pkg::data_t  rdata
);
   import pibus_pkg::*;

   localparam int idx_w  = (mem_words > 1) ? $clog2(mem_words) : 1;
   localparam int wcnt_w = (wait_states > 0) ? $clog2(wait_states + 1) : 1;

   data_t             mem [mem_words];
   addr_t             cap_a;
   opc_t              cap_opc;
   data_t             cap_wdata;
   logic              busy;
   logic              err_q;
   logic              done;
   logic [wcnt_w-1:0] wait_cnt;
   logic [idx_w-1:0]  idx;

   assign done = busy && (wait_cnt == wcnt_w'(wait_states));
   assign idx  = idx_w'(cap_a % addr_t'(mem_words));   // wraps onto memory

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         busy     <= 1'b0;
         err_q    <= 1'b0;
         wait_cnt <= '0;
      end
      else
      begin
         err_q <= 1'b0;
         if (done)
            busy <= 1'b0;
         else if (busy)
            wait_cnt <= wait_cnt + 1'b1;
         else if (sel)
         begin
            if (opc >= OPC_LIMIT)
               err_q <= 1'b1;        // reject, memory untouched
            else
            begin
               busy     <= 1'b1;
               wait_cnt <= '0;
            end
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (sel && !busy)
      begin
         cap_a     <= a;
         cap_opc   <= opc;
         cap_wdata <= wdata;
      end
   end

   always_ff @(posedge clk)
   begin
      if (done && (cap_opc == OPC_WRITE))
         mem[idx] <= cap_wdata;
   end

   always_comb
   begin
      if (done)
         ack = ACK_RDY;
      else if (busy)
         ack = ACK_WAT;
      else if (err_q)
         ack = ACK_ERR;
      else
         ack = ACK_NONE;
   end

   // read data only in the ready cycle
   assign rdata = (done && (cap_opc != OPC_WRITE)) ? mem[idx] : '0;

endmodule

//--- verilog/pibus_mux.sv
`timescale 1ns/1ns

module pibus_mux (
   input  logic              clk,
   input  logic              rst,
   input  logic              gnt_0,
   input  logic              gnt_1,
   input  pibus_pkg::addr_t  a_0,
   input  pibus_pkg::addr_t  a_1,
   input  pibus_pkg::opc_t   opc_0,
   input  pibus_pkg::opc_t   opc_1,
   input  logic              lock_0,
   input  logic              lock_1,
   input  pibus_pkg::data_t  wdata_0,
   input  pibus_pkg::data_t  wdata_1,
   output pibus_pkg::addr_t  a,
   output pibus_pkg::opc_t   opc,
   output logic              lock,
   output pibus_pkg::data_t  wdata
);

   logic owner;      // 1 when master 1 holds the bus
   logic granted;    // any grant seen since reset

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         owner   <= 1'b0;
         granted <= 1'b0;
      end
      else if (gnt_0 || gnt_1)
      begin
         owner   <= gnt_1;
         granted <= 1'b1;
      end
   end

   always_comb
   begin
      a     = owner ? a_1 : a_0;
      wdata = owner ? wdata_1 : wdata_0;
      if (granted)
      begin
         opc  = owner ? opc_1 : opc_0;
         lock = owner ? lock_1 : lock_0;
      end
      else
      begin
         opc  = '0;         // idle bus carries NOP
         lock = 1'b0;
      end
   end

endmodule

//--- verilog/bus_cont.sv
`timescale 1ns/1ns

module bus_cont #(
   parameter int tout_limit = 255
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              req_0,
   input  logic              req_1,
   input  pibus_pkg::addr_t  a,
   input  pibus_pkg::opc_t   opc,
   input  logic              lock,
   input  pibus_pkg::ack_t   ack,
   output logic              gnt_0,
   output logic              gnt_1,
   output logic              sel,
   output logic              tout
);
   import pibus_pkg::*;

   localparam int cnt_w = $clog2(tout_limit + 1);

   bus_state_t       state;
   bus_state_t       state_n;
   logic             gnt_0_n;
   logic             gnt_1_n;
   logic             tie_1;        // master 1 wins the next tie
   logic             tie_1_n;
   logic             select_reg;
   logic             select_n;
   logic             tout_n;
   logic [cnt_w-1:0] tout_cnt;
   logic             in_data;
   logic             tout_hit;
   logic             rearb;        // hand the bus on or go idle

   assign in_data  = (state == BUS_ADDRDATA) || (state == BUS_DATA);
   assign tout_hit = in_data && (tout_cnt == cnt_w'(tout_limit - 1));

   // slave decode: top two address bits set
   assign sel = select_reg && a[0] && a[1];

   always_comb
   begin
      state_n  = state;
      gnt_0_n  = 1'b0;
      gnt_1_n  = 1'b0;
      tie_1_n  = tie_1;
      select_n = 1'b0;
      tout_n   = 1'b0;
      rearb    = 1'b0;

      case (state)
         BUS_IDLE:
         begin
            rearb = 1'b1;
         end
         BUS_REQ:
         begin
            state_n = BUS_ADDR;   // new owner drives its fields now
         end
         BUS_ADDR:
         begin
            if (opc == '0)
            begin
               if (!lock)
                  rearb = 1'b1;      // tenure over
            end
            else
            begin
               select_n = 1'b1;
               state_n  = lock ? BUS_ADDRDATA : BUS_DATA;
            end
         end
         BUS_ADDRDATA,
         BUS_DATA:
         begin
            if (tout_hit || (ack == ACK_ERR))
            begin
               tout_n  = 1'b1;
               state_n = BUS_IDLE;
            end
            else if (ack == ACK_RDY)
            begin
               if (state == BUS_ADDRDATA)
                  state_n = BUS_ADDR;   // locked, owner keeps the bus
               else
                  rearb = 1'b1;
            end
         end
         default:
         begin
            state_n = BUS_IDLE;
         end
      endcase

      // one arbitration point for every state that releases the bus
      if (rearb)
      begin
         if (req_0 || req_1)
         begin
            gnt_0_n = req_0 && (!req_1 || !tie_1);
            gnt_1_n = req_1 && (!req_0 || tie_1);
            tie_1_n = gnt_0_n;     // other master wins next tie
            state_n = BUS_REQ;
         end
         else
         begin
            state_n = BUS_IDLE;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state      <= BUS_IDLE;
         gnt_0      <= 1'b0;
         gnt_1      <= 1'b0;
         tie_1      <= 1'b0;
         select_reg <= 1'b0;
         tout       <= 1'b0;
      end
      else
      begin
         state      <= state_n;
         gnt_0      <= gnt_0_n;    // one-cycle pulse
         gnt_1      <= gnt_1_n;
         tie_1      <= tie_1_n;
         select_reg <= select_n;
         tout       <= tout_n;
      end
   end

   // counts data-phase cycles only
   always_ff @(posedge clk)
   begin
      if (rst || !in_data)
         tout_cnt <= '0;
      else
         tout_cnt <= tout_cnt + 1'b1;
   end

endmodule

//--- verilog/pibus_pkg.sv
package pibus_pkg;

   localparam int addr_w = 30;
   localparam int opc_w  = 4;
   localparam int data_w = 32;

   // word address, bit 0 is the msb
   typedef logic [0:addr_w-1] addr_t;
   typedef logic [0:opc_w-1]  opc_t;   // zero is NOP
   typedef logic [data_w-1:0] data_t;

   typedef enum logic [1:0] {
      ACK_NONE,
      ACK_WAT,
      ACK_RDY,
      ACK_ERR
   } ack_t;

   typedef enum logic [2:0] {
      BUS_IDLE,
      BUS_REQ,
      BUS_ADDR,
      BUS_ADDRDATA,
      BUS_DATA
   } bus_state_t;

   localparam opc_t OPC_WRITE = 4'h1;
   localparam opc_t OPC_LIMIT = 4'h8;   // illegal from here up

endpackage
